/* vlog.f */
glb_pkg.sv
glb_axil_cfg_bridge.sv
glb_cfg_router.sv
glb_intr_ctrl.sv
glb_tile_dma_ctrl.sv
glb_ctrl_top.sv
tb_glb_ctrl.sv

/* tb_glb_ctrl.sv */
// global buffer control testbench
module tb_glb_ctrl import glb_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TILES  = 4;
    // 400 transactions at up to 40 cycles each
    localparam int MAX_CYCLES = 400 * 40;

    logic      clk;
    logic      reset;
    logic      cfg_wr_clk_en;
    logic      cfg_rd_clk_en;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      interrupt;

    // register model
    logic [7:0]  ier_m;
    logic [7:0]  isr_m;
    logic [15:0] len_m [NUM_TILES][2];
    int          cycles = 0;

    glb_ctrl_top #(
        .NUM_TILES (NUM_TILES)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .cfg_wr_clk_en (cfg_wr_clk_en),
        .cfg_rd_clk_en (cfg_rd_clk_en),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .interrupt     (interrupt)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("=== FAIL ===");
            $fatal(1, "run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    // byte address of a global register
    function automatic logic [11:0] glb_addr(input logic [3:0] off);
        return {2'b00, 1'b0, 3'b000, off, 2'b00};
    endfunction

    // byte address of a tile register, region bit set
    function automatic logic [11:0] tile_addr(input int t, input logic [2:0] off);
        return {2'b00, 1'b1, 4'(t), off, 2'b00};
    endfunction

    function automatic logic [11:0] len_addr(input int t, input int ch);
        return tile_addr(t, (ch == 0) ? TREG_ST_LEN : TREG_LD_LEN);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // stall > 0 holds the write enable low for that many cycles
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              input int stall);
        int hold;
        hold = $urandom % 4;
        if (stall > 0) begin
            cfg_wr_clk_en <= 1'b0;
        end
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.bready  <= 1'b0;
        do @(posedge clk); while (!axil_rsp.awready);
        // address and data are taken together
        check_value("wready", 32'(axil_rsp.wready), 32'd1);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        // no strobe, so no response yet
        repeat (stall) begin
            @(posedge clk);
            check_value("bvalid", 32'(axil_rsp.bvalid), 32'd0);
        end
        cfg_wr_clk_en <= 1'b1;
        do @(posedge clk); while (!axil_rsp.bvalid);
        check_value("bresp", 32'(axil_rsp.bresp), 32'(AXIL_RESP_OKAY));
        // back-pressure on the response
        repeat (hold) @(posedge clk);
        axil_req.bready <= 1'b1;
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                             input int stall);
        int hold;
        hold = $urandom % 4;
        if (stall > 0) begin
            cfg_rd_clk_en <= 1'b0;
        end
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b0;
        do @(posedge clk); while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        repeat (stall) begin
            @(posedge clk);
            check_value("rvalid", 32'(axil_rsp.rvalid), 32'd0);
        end
        cfg_rd_clk_en <= 1'b1;
        do @(posedge clk); while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        check_value("rresp", 32'(axil_rsp.rresp), 32'(AXIL_RESP_OKAY));
        repeat (hold) @(posedge clk);
        axil_req.rready <= 1'b1;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic check_interrupt();
        check_value("interrupt", 32'(interrupt), 32'(|isr_m));
    endtask

    // every modeled register against the model
    task automatic verify_regs();
        logic [31:0] got;
        axil_read(glb_addr(ADDR_IER), got, 0);
        check_value("ier", got, 32'(ier_m));
        axil_read(glb_addr(ADDR_ISR), got, 0);
        check_value("isr", got, 32'(isr_m));
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int ch = 0; ch < 2; ch++) begin
                axil_read(len_addr(t, ch), got, 0);
                check_value("len", got, 32'(len_m[t][ch]));
            end
        end
        check_interrupt();
    endtask

    task automatic readback_regs();
        logic [31:0] data;
        logic [31:0] got;
        int          t;
        int          ch;
        for (int i = 0; i < 8; i++) begin
            data = $urandom;
            axil_write(glb_addr(ADDR_IER), data, 0);
            ier_m = data[7:0];
            axil_read(glb_addr(ADDR_IER), got, 0);
            check_value("ier", got, 32'(ier_m));
        end
        for (int i = 0; i < 16; i++) begin
            t    = $urandom % NUM_TILES;
            ch   = $urandom % 2;
            data = $urandom;
            axil_write(len_addr(t, ch), data, 0);
            len_m[t][ch] = data[15:0];
            axil_read(len_addr(t, ch), got, 0);
            check_value("len", got, 32'(len_m[t][ch]));
        end
    endtask

    // one channel run, status bit only if enabled
    task automatic run_channel(input int t, input int ch, input logic en);
        int          b;
        logic [31:0] len;
        logic [31:0] stat;
        logic [31:0] got;
        b = 2 * t + ch;
        if (isr_m[b]) begin
            axil_write(glb_addr(ADDR_ISR), 32'd1 << b, 0);
            isr_m[b] = 1'b0;
        end
        ier_m[b] = en;
        axil_write(glb_addr(ADDR_IER), 32'(ier_m), 0);
        len = $urandom % 21;
        axil_write(len_addr(t, ch), len, 0);
        len_m[t][ch] = len[15:0];
        axil_write(tile_addr(t, TREG_CTRL), 32'd1 << ch, 0);
        axil_read(tile_addr(t, TREG_STAT), stat, 0);
        // long runs are still busy at the first poll
        if (len >= 12) begin
            check_value("stat busy", 32'(stat[ch]), 32'd1);
        end
        while (stat[ch]) begin
            axil_read(tile_addr(t, TREG_STAT), stat, 0);
        end
        check_value("stat", stat, 32'd0);
        isr_m[b] = en;
        axil_read(glb_addr(ADDR_ISR), got, 0);
        check_value("isr", got, 32'(isr_m));
        check_interrupt();
    endtask

    // fill status from several channels, then clear in random pieces
    task automatic clear_status();
        logic [31:0] got;
        logic [31:0] stat;
        logic [1:0]  ctrl [NUM_TILES];
        logic [7:0]  mask;
        for (int round = 0; round < 3; round++) begin
            ier_m = 8'hff;
            axil_write(glb_addr(ADDR_IER), 32'(ier_m), 0);
            for (int t = 0; t < NUM_TILES; t++) begin
                ctrl[t] = 2'($urandom % 4);
                if (ctrl[t] != 2'b00) begin
                    for (int ch = 0; ch < 2; ch++) begin
                        len_m[t][ch] = 16'($urandom % 21);
                        axil_write(len_addr(t, ch), 32'(len_m[t][ch]), 0);
                    end
                    axil_write(tile_addr(t, TREG_CTRL), 32'(ctrl[t]), 0);
                end
            end
            for (int t = 0; t < NUM_TILES; t++) begin
                do begin
                    axil_read(tile_addr(t, TREG_STAT), stat, 0);
                end while (stat != 32'd0);
                isr_m[2*t]   = isr_m[2*t] | ctrl[t][0];
                isr_m[2*t+1] = isr_m[2*t+1] | ctrl[t][1];
            end
            axil_read(glb_addr(ADDR_ISR), got, 0);
            check_value("isr", got, 32'(isr_m));
            check_interrupt();
            while (isr_m != 8'd0) begin
                mask = 8'($urandom) & isr_m;
                axil_write(glb_addr(ADDR_ISR), 32'(mask), 0);
                isr_m = isr_m & ~mask;
                axil_read(glb_addr(ADDR_ISR), got, 0);
                check_value("isr", got, 32'(isr_m));
                check_interrupt();
            end
        end
    endtask

    task automatic unmapped_access();
        logic [31:0] got;
        logic [11:0] addr;
        for (int off = 2; off < 16; off++) begin
            addr = glb_addr(4'(off));
            axil_read(addr, got, 0);
            check_value("unmapped global", got, 32'd0);
            axil_write(addr, $urandom, 0);
        end
        for (int id = NUM_TILES; id < 16; id++) begin
            addr = tile_addr(id, 3'($urandom % 4));
            axil_read(addr, got, 0);
            check_value("unmapped tile", got, 32'd0);
            axil_write(addr, $urandom, 0);
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            addr = tile_addr(t, 3'd5);
            axil_read(addr, got, 0);
            check_value("unmapped offset", got, 32'd0);
            axil_write(addr, $urandom, 0);
        end
        verify_regs();
    endtask

    // accesses held back by a low clock enable
    task automatic gated_access();
        logic [31:0] data;
        logic [31:0] got;
        int          t;
        int          ch;
        for (int i = 0; i < 8; i++) begin
            t    = $urandom % NUM_TILES;
            ch   = $urandom % 2;
            data = $urandom;
            axil_write(len_addr(t, ch), data, 1 + $urandom % 10);
            len_m[t][ch] = data[15:0];
            axil_read(len_addr(t, ch), got, 1 + $urandom % 10);
            check_value("len", got, 32'(len_m[t][ch]));
            data = $urandom;
            axil_write(glb_addr(ADDR_IER), data, 1 + $urandom % 10);
            ier_m = data[7:0];
            axil_read(glb_addr(ADDR_IER), got, 1 + $urandom % 10);
            check_value("ier", got, 32'(ier_m));
        end
    endtask

    initial begin
        void'($urandom(43338));
        reset         = 1'b1;
        cfg_wr_clk_en = 1'b1;
        cfg_rd_clk_en = 1'b1;
        axil_req      = '0;
        ier_m         = '0;
        isr_m         = '0;
        for (int t = 0; t < NUM_TILES; t++) begin
            len_m[t][0] = '0;
            len_m[t][1] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        // handshake outputs idle out of reset
        check_value("axil valid/ready",
                    32'({axil_rsp.awready, axil_rsp.wready, axil_rsp.arready,
                         axil_rsp.bvalid, axil_rsp.rvalid}), 32'd0);
        verify_regs();
        readback_regs();
        for (int i = 0; i < 24; i++) begin
            run_channel($urandom % NUM_TILES, $urandom % 2, 1'($urandom % 2));
        end
        clear_status();
        unmapped_access();
        gated_access();
        verify_regs();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* glb_ctrl_top.sv */
// global buffer control top
module glb_ctrl_top import glb_pkg::*; #(
    parameter int NUM_TILES = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      cfg_wr_clk_en,
    input  logic      cfg_rd_clk_en,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      interrupt
);

    // bridge to router
    cfg_req_t bridge_req;
    cfg_rsp_t bridge_rsp;

    // router to targets
    cfg_req_t                 intr_req;
    cfg_rsp_t                 intr_rsp;
    cfg_req_t [NUM_TILES-1:0] tile_req;
    cfg_rsp_t [NUM_TILES-1:0] tile_rsp;

    // store done at 2t, load done at 2t+1
    logic [2*NUM_TILES-1:0] dma_done;

    glb_axil_cfg_bridge u_bridge (
        .clk           (clk),
        .reset         (reset),
        .cfg_wr_clk_en (cfg_wr_clk_en),
        .cfg_rd_clk_en (cfg_rd_clk_en),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .cfg_req       (bridge_req),
        .cfg_rsp       (bridge_rsp)
    );

    glb_cfg_router #(
        .NUM_TILES (NUM_TILES)
    ) u_router (
        .clk      (clk),
        .reset    (reset),
        .cfg_req  (bridge_req),
        .cfg_rsp  (bridge_rsp),
        .intr_req (intr_req),
        .intr_rsp (intr_rsp),
        .tile_req (tile_req),
        .tile_rsp (tile_rsp)
    );

    glb_intr_ctrl #(
        .NUM_TILES (NUM_TILES)
    ) u_intr (
        .clk                    (clk),
        .reset                  (reset),
        .cfg_wr_clk_en          (cfg_wr_clk_en),
        .cfg_rd_clk_en          (cfg_rd_clk_en),
        .cfg_req                (intr_req),
        .cfg_rsp                (intr_rsp),
        .interrupt_pulse_bundle (dma_done),
        .interrupt              (interrupt)
    );

    // one dma block per tile
    for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
        glb_tile_dma_ctrl u_dma (
            .clk           (clk),
            .reset         (reset),
            .cfg_wr_clk_en (cfg_wr_clk_en),
            .cfg_rd_clk_en (cfg_rd_clk_en),
            .cfg_req       (tile_req[t]),
            .cfg_rsp       (tile_rsp[t]),
            .st_done       (dma_done[2*t]),
            .ld_done       (dma_done[2*t+1])
        );
    end

endmodule

/* glb_tile_dma_ctrl.sv */
// tile dma control registers
module glb_tile_dma_ctrl import glb_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     cfg_wr_clk_en,
    input  logic     cfg_rd_clk_en,
    input  cfg_req_t cfg_req,
    output cfg_rsp_t cfg_rsp,
    output logic     st_done,
    output logic     ld_done
);

    localparam int LEN_WIDTH = 16;

    // channel 0 is store, channel 1 is load
    logic [1:0][LEN_WIDTH-1:0] len_q;
    logic [1:0][LEN_WIDTH-1:0] cnt_q;
    logic [1:0]                busy_q;
    logic [1:0]                done_q;
    logic [1:0]                start;

    // read mux output
    logic [CFG_DATA_WIDTH-1:0] rd_word;

    // start bits of a ctrl write, by channel
    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            start[ch] = cfg_wr_clk_en && cfg_req.wr_en
                        && cfg_req.wr_addr.tile.offset == TREG_CTRL
                        && cfg_req.wr_data[ch];
        end
    end

    // length registers, low half of the word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            len_q <= '0;
        end
        else if (cfg_wr_clk_en && cfg_req.wr_en) begin
            case (cfg_req.wr_addr.tile.offset)
                TREG_ST_LEN: len_q[0] <= cfg_req.wr_data[LEN_WIDTH-1:0];
                TREG_LD_LEN: len_q[1] <= cfg_req.wr_data[LEN_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // countdown per channel
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt_q  <= '0;
            busy_q <= '0;
            done_q <= '0;
        end
        else begin
            for (int ch = 0; ch < 2; ch++) begin
                // done follows the last busy cycle
                done_q[ch] <= busy_q[ch] && cnt_q[ch] == '0;
                if (busy_q[ch]) begin
                    if (cnt_q[ch] == '0) begin
                        busy_q[ch] <= 1'b0;
                    end
                    else begin
                        cnt_q[ch] <= cnt_q[ch] - 1'b1;
                    end
                end
                // start while busy is dropped
                else if (start[ch]) begin
                    busy_q[ch] <= 1'b1;
                    cnt_q[ch]  <= len_q[ch];
                end
            end
        end
    end

    assign st_done = done_q[0];
    assign ld_done = done_q[1];

    always_comb begin
        case (cfg_req.rd_addr.tile.offset)
            TREG_ST_LEN: rd_word = CFG_DATA_WIDTH'(len_q[0]);
            TREG_LD_LEN: rd_word = CFG_DATA_WIDTH'(len_q[1]);
            TREG_STAT:   rd_word = CFG_DATA_WIDTH'(busy_q);
            // ctrl is write-only
            default:     rd_word = '0;
        endcase
    end

    // registered read, zero when not addressed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_rsp <= '0;
        end
        else if (cfg_rd_clk_en && cfg_req.rd_en) begin
            cfg_rsp.rd_data       <= rd_word;
            cfg_rsp.rd_data_valid <= 1'b1;
        end
        else begin
            cfg_rsp <= '0;
        end
    end

    // done only after a busy cycle on that channel
    a_st_done_busy: assert property (
        @(posedge clk) disable iff (reset)
        st_done |-> $past(busy_q[0])
    );
    a_ld_done_busy: assert property (
        @(posedge clk) disable iff (reset)
        ld_done |-> $past(busy_q[1])
    );

endmodule

/* glb_intr_ctrl.sv */
// global buffer interrupt controller
module glb_intr_ctrl import glb_pkg::*; #(
    parameter int NUM_TILES = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_wr_clk_en,
    input  logic                   cfg_rd_clk_en,
    input  cfg_req_t               cfg_req,
    output cfg_rsp_t               cfg_rsp,
    input  logic [2*NUM_TILES-1:0] interrupt_pulse_bundle,
    output logic                   interrupt
);

    // bit 2t is tile t store, bit 2t+1 is tile t load
    logic [2*NUM_TILES-1:0] ier_q;
    logic [2*NUM_TILES-1:0] isr_q;

    // write decode
    logic ier_wr;
    logic isr_wr;

    // read mux output
    logic [CFG_DATA_WIDTH-1:0] rd_word;

    assign ier_wr = cfg_req.wr_en && cfg_req.wr_addr.glb.offset == ADDR_IER;
    assign isr_wr = cfg_req.wr_en && cfg_req.wr_addr.glb.offset == ADDR_ISR;

    // enable register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ier_q <= '0;
        end
        else if (cfg_wr_clk_en && ier_wr) begin
            ier_q <= cfg_req.wr_data[2*NUM_TILES-1:0];
        end
    end

    // status register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            isr_q <= '0;
        end
        else if (cfg_wr_clk_en) begin
            for (int i = 0; i < 2*NUM_TILES; i++) begin
                // a pulse wins over a clearing write
                if (ier_q[i] && interrupt_pulse_bundle[i]) begin
                    isr_q[i] <= 1'b1;
                end
                else if (isr_wr) begin
                    // toggle, so writing one to a set bit clears it
                    isr_q[i] <= isr_q[i] ^ cfg_req.wr_data[i];
                end
            end
        end
    end

    // level interrupt
    assign interrupt = |isr_q;

    always_comb begin
        rd_word = '0;
        case (cfg_req.rd_addr.glb.offset)
            ADDR_IER: rd_word[2*NUM_TILES-1:0] = ier_q;
            ADDR_ISR: rd_word[2*NUM_TILES-1:0] = isr_q;
            default:  rd_word = '0;
        endcase
    end

    // registered read port
    // rd_data stays zero when idle for the router merge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_rsp <= '0;
        end
        else if (cfg_rd_clk_en && cfg_req.rd_en) begin
            cfg_rsp.rd_data       <= rd_word;
            cfg_rsp.rd_data_valid <= 1'b1;
        end
        else begin
            cfg_rsp <= '0;
        end
    end

    // all done bits must fit one register word
    a_bundle_fits: assert property (
        @(posedge clk) 2*NUM_TILES <= CFG_DATA_WIDTH
    );

endmodule

/* glb_cfg_router.sv */
// config bus address router
module glb_cfg_router import glb_pkg::*; #(
    parameter int NUM_TILES = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  cfg_req_t                 cfg_req,
    output cfg_rsp_t                 cfg_rsp,
    output cfg_req_t                 intr_req,
    input  cfg_rsp_t                 intr_rsp,
    output cfg_req_t [NUM_TILES-1:0] tile_req,
    input  cfg_rsp_t [NUM_TILES-1:0] tile_rsp
);

    // per-target strobe selects
    logic                 intr_wr_sel;
    logic                 intr_rd_sel;
    logic [NUM_TILES-1:0] tile_wr_sel;
    logic [NUM_TILES-1:0] tile_rd_sel;

    // zero response for unmapped reads
    logic miss_valid_q;

    always_comb begin
        // global view, only ier and isr exist
        intr_wr_sel = cfg_req.wr_en && !cfg_req.wr_addr.glb.region
                      && (cfg_req.wr_addr.glb.offset == ADDR_IER
                          || cfg_req.wr_addr.glb.offset == ADDR_ISR);
        intr_rd_sel = cfg_req.rd_en && !cfg_req.rd_addr.glb.region
                      && (cfg_req.rd_addr.glb.offset == ADDR_IER
                          || cfg_req.rd_addr.glb.offset == ADDR_ISR);
        // tile view, ids past NUM_TILES never match
        for (int t = 0; t < NUM_TILES; t++) begin
            tile_wr_sel[t] = cfg_req.wr_en && cfg_req.wr_addr.tile.region
                             && cfg_req.wr_addr.tile.tile_id == 4'(t)
                             && cfg_req.wr_addr.tile.offset <= TREG_STAT;
            tile_rd_sel[t] = cfg_req.rd_en && cfg_req.rd_addr.tile.region
                             && cfg_req.rd_addr.tile.tile_id == 4'(t)
                             && cfg_req.rd_addr.tile.offset <= TREG_STAT;
        end
    end

    // copy request out, strobes gated per target
    always_comb begin
        intr_req       = cfg_req;
        intr_req.wr_en = intr_wr_sel;
        intr_req.rd_en = intr_rd_sel;
        for (int t = 0; t < NUM_TILES; t++) begin
            tile_req[t]       = cfg_req;
            tile_req[t].wr_en = tile_wr_sel[t];
            tile_req[t].rd_en = tile_rd_sel[t];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            miss_valid_q <= 1'b0;
        end
        else begin
            miss_valid_q <= cfg_req.rd_en && !intr_rd_sel && !(|tile_rd_sel);
        end
    end

    // idle targets hold rd_data at zero, so an or is enough
    always_comb begin
        cfg_rsp.rd_data       = intr_rsp.rd_data;
        cfg_rsp.rd_data_valid = intr_rsp.rd_data_valid | miss_valid_q;
        for (int t = 0; t < NUM_TILES; t++) begin
            cfg_rsp.rd_data       = cfg_rsp.rd_data | tile_rsp[t].rd_data;
            cfg_rsp.rd_data_valid = cfg_rsp.rd_data_valid | tile_rsp[t].rd_data_valid;
        end
    end

    // bridge serializes transactions, so one target at a time
    a_one_target: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({intr_wr_sel, intr_rd_sel, tile_wr_sel, tile_rd_sel})
    );

endmodule

/* glb_axil_cfg_bridge.sv */
// axi-lite to config bus bridge
module glb_axil_cfg_bridge import glb_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      cfg_wr_clk_en,
    input  logic      cfg_rd_clk_en,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output cfg_req_t  cfg_req,
    input  cfg_rsp_t  cfg_rsp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR_PEND,
        ST_WR_RESP,
        ST_RD_PEND,
        ST_RD_WAIT,
        ST_RD_RESP
    } state_t;

    state_t state_q;
    state_t state_d;

    // captured transaction payload
    logic [CFG_ADDR_WIDTH-1:0] addr_q;
    logic [CFG_DATA_WIDTH-1:0] wdata_q;
    logic [CFG_DATA_WIDTH-1:0] rdata_q;

    // handshakes, only from idle
    logic wr_accept;
    logic rd_accept;

    // write has priority over a read arriving in the same cycle
    assign wr_accept = (state_q == ST_IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign rd_accept = (state_q == ST_IDLE) && axil_req.arvalid && !wr_accept;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (wr_accept) begin
                    state_d = ST_WR_PEND;
                end
                else if (rd_accept) begin
                    state_d = ST_RD_PEND;
                end
            end
            // strobe goes out this cycle if enabled
            ST_WR_PEND: begin
                if (cfg_wr_clk_en) begin
                    state_d = ST_WR_RESP;
                end
            end
            ST_WR_RESP: begin
                if (axil_req.bready) begin
                    state_d = ST_IDLE;
                end
            end
            ST_RD_PEND: begin
                if (cfg_rd_clk_en) begin
                    state_d = ST_RD_WAIT;
                end
            end
            // target answers one cycle after the strobe
            ST_RD_WAIT: begin
                if (cfg_rsp.rd_data_valid) begin
                    state_d = ST_RD_RESP;
                end
            end
            ST_RD_RESP: begin
                if (axil_req.rready) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end
        else begin
            state_q <= state_d;
        end
    end

    // address and data capture
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            addr_q  <= axil_req.awaddr;
            wdata_q <= axil_req.wdata;
        end
        else if (rd_accept) begin
            addr_q <= axil_req.araddr;
        end
        if (state_q == ST_RD_WAIT && cfg_rsp.rd_data_valid) begin
            rdata_q <= cfg_rsp.rd_data;
        end
    end

    // single-cycle config strobes
    always_comb begin
        cfg_req.wr_en   = (state_q == ST_WR_PEND) && cfg_wr_clk_en;
        cfg_req.wr_addr = addr_q;
        cfg_req.wr_data = wdata_q;
        cfg_req.rd_en   = (state_q == ST_RD_PEND) && cfg_rd_clk_en;
        cfg_req.rd_addr = addr_q;
    end

    // host side channels
    always_comb begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bvalid  = (state_q == ST_WR_RESP);
        axil_rsp.bresp   = AXIL_RESP_OKAY;
        axil_rsp.arready = rd_accept;
        axil_rsp.rvalid  = (state_q == ST_RD_RESP);
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = AXIL_RESP_OKAY;
    end

    // no target may answer unless a read is in flight
    a_rsp_in_rd_wait: assert property (
        @(posedge clk) disable iff (reset)
        cfg_rsp.rd_data_valid |-> state_q == ST_RD_WAIT
    );

endmodule

/* glb_pkg.sv */
// global buffer control package
package glb_pkg;

    // bus widths
    localparam int CFG_DATA_WIDTH = 32;
    localparam int CFG_ADDR_WIDTH = 12;

    // global register word offsets
    localparam logic [3:0] ADDR_IER = 4'd0;
    localparam logic [3:0] ADDR_ISR = 4'd1;

    // tile register word offsets
    localparam logic [2:0] TREG_ST_LEN = 3'd0;
    localparam logic [2:0] TREG_LD_LEN = 3'd1;
    localparam logic [2:0] TREG_CTRL   = 3'd2;
    localparam logic [2:0] TREG_STAT   = 3'd3;

    // axi-lite okay response
    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // global view, region bit low
    typedef struct packed {
        logic [1:0] spare;
        logic       region;
        logic [2:0] pad;
        logic [3:0] offset;
        logic [1:0] byte_sel;
    } cfg_glb_addr_t;

    // tile view, region bit high
    typedef struct packed {
        logic [1:0] spare;
        logic       region;
        logic [3:0] tile_id;
        logic [2:0] offset;
        logic [1:0] byte_sel;
    } cfg_tile_addr_t;

    // one address word, decoded either way by the region bit
    typedef union packed {
        logic [CFG_ADDR_WIDTH-1:0] raw;
        cfg_glb_addr_t             glb;
        cfg_tile_addr_t            tile;
    } glb_cfg_addr_u;

    typedef struct packed {
        logic                      wr_en;
        glb_cfg_addr_u             wr_addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
        logic                      rd_en;
        glb_cfg_addr_u             rd_addr;
    } cfg_req_t;

    typedef struct packed {
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      rd_data_valid;
    } cfg_rsp_t;

    // host to slave
    typedef struct packed {
        logic                      awvalid;
        logic [CFG_ADDR_WIDTH-1:0] awaddr;
        logic                      wvalid;
        logic [CFG_DATA_WIDTH-1:0] wdata;
        logic                      bready;
        logic                      arvalid;
        logic [CFG_ADDR_WIDTH-1:0] araddr;
        logic                      rready;
    } axil_req_t;

    // slave to host
    typedef struct packed {
        logic                      awready;
        logic                      wready;
        logic                      bvalid;
        logic [1:0]                bresp;
        logic                      arready;
        logic                      rvalid;
        logic [CFG_DATA_WIDTH-1:0] rdata;
        logic [1:0]                rresp;
    } axil_rsp_t;

endpackage
